//--- logic/line_buffer_pkg.sv
package line_buffer_pkg;

    // one FIFO word. written as colour fields, read back as two bytes.
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef union packed {
        rgb565_t         rgb;
        logic [1:0][7:0] bytes; // [1] is the high byte.
    } pixel565_t;

    // frame capture FSM.
    typedef enum logic [1:0] {
        WAIT_TRIG = 2'd0, // frame start, no pixel seen yet.
        CAPTURE   = 2'd1,
        SKIP      = 2'd2, // trigger came too late for this frame.
        DONE      = 2'd3
    } capture_state_t;

endpackage : line_buffer_pkg

//--- logic/pixel_capture.sv
module pixel_capture #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                       rclk,
    input  logic                       cam_vsync,
    input  logic                       trig,
    input  logic [24:0]                cam_pack,
    output logic                       wr_en,
    output line_buffer_pkg::pixel565_t wr_data
);

    localparam int FRAME_PIX = H_ACT * V_ACT;
    localparam int CNT_W     = $clog2(FRAME_PIX + 1);

    logic                             cam_de;
    logic [7:0]                       cam_r;
    logic [7:0]                       cam_g;
    logic [7:0]                       cam_b;
    line_buffer_pkg::pixel565_t       pix565;
    line_buffer_pkg::capture_state_t  state;
    logic                             trig_q;
    logic [CNT_W-1:0]                 pix_cnt;
    logic                             pix_last;
    logic                             capture_now;

    // unpack the camera word.
    assign cam_de = cam_pack[24];
    assign cam_r  = cam_pack[23:16];
    assign cam_g  = cam_pack[15:8];
    assign cam_b  = cam_pack[7:0];

    // truncate to 5/6/5.
    always_comb begin
        pix565.rgb.r = cam_r[7:3];
        pix565.rgb.g = cam_g[7:2];
        pix565.rgb.b = cam_b[7:3];
    end

    assign pix_last = (pix_cnt == CNT_W'(FRAME_PIX - 1));

    // a latched trigger lets the very first pixel through.
    assign capture_now = cam_de &&
                         ((state == line_buffer_pkg::CAPTURE) ||
                          (state == line_buffer_pkg::WAIT_TRIG && trig_q));

    // trigger latch, held until the next frame start.
    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            trig_q <= 1'b0;
        end else if (trig) begin
            trig_q <= 1'b1;
        end
    end

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            state   <= line_buffer_pkg::WAIT_TRIG;
            pix_cnt <= '0;
            wr_en   <= 1'b0;
        end else begin
            wr_en <= capture_now;
            if (capture_now) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_last) begin
                    state <= line_buffer_pkg::DONE; // one frame only.
                end else begin
                    state <= line_buffer_pkg::CAPTURE;
                end
            end else if (state == line_buffer_pkg::WAIT_TRIG) begin
                if (trig_q) begin
                    state <= line_buffer_pkg::CAPTURE;
                end else if (cam_de) begin
                    state <= line_buffer_pkg::SKIP; // frame already running.
                end
            end
        end
    end

    // word travels alongside wr_en.
    always_ff @(posedge rclk) begin
        if (capture_now) begin
            wr_data <= pix565;
        end
    end

endmodule : pixel_capture

//--- logic/line_fifo.sv
module line_fifo #(
    parameter int FIFO_DEPTH = 2560,
    parameter int H_ACT      = 1280
) (
    input  logic                       rclk,
    input  logic                       cam_vsync,
    input  logic                       wr_en,
    input  line_buffer_pkg::pixel565_t wr_data,
    input  logic                       rd_ready,
    output line_buffer_pkg::pixel565_t rd_data,
    output logic                       rd_valid,
    output logic                       aquire,
    output logic                       error
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

    line_buffer_pkg::pixel565_t mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]          wr_ptr;
    logic [ADDR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       full;
    logic                       do_wr;
    logic                       do_rd;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign do_wr    = wr_en && !full;
    assign do_rd    = rd_valid && rd_ready;
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr]; // first-word fall-through.
    assign aquire   = (count >= CNT_W'(H_ACT)); // a whole line is waiting.

    always_ff @(posedge rclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            error  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                end
            endcase
            // pixel lost, sticky until the next frame.
            if (wr_en && full) begin
                error <= 1'b1;
            end
        end
    end

endmodule : line_fifo

//--- logic/byte_reader.sv
module byte_reader #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                             rclk,
    input  logic                             cam_vsync,
    input  line_buffer_pkg::pixel565_t       rd_data,
    input  logic                             rd_valid,
    input  logic                             read_en,
    output logic                             rd_ready,
    output logic                             cam_valid,
    output logic [7:0]                       cam_data,
    output logic [$clog2(2 * V_ACT)-1:0]     cam_row
);

    localparam int ROWS  = 2 * V_ACT; // two bytes per pixel.
    localparam int X_W   = $clog2(H_ACT);
    localparam int ROW_W = $clog2(ROWS);

    line_buffer_pkg::pixel565_t word_q;
    logic                       word_valid;
    logic                       byte_sel; // 0 high byte, 1 low byte.
    logic                       take;
    logic                       last_take;
    logic                       load;
    logic [X_W-1:0]             x;
    logic [ROW_W-1:0]           row;
    logic                       x_end;
    logic                       row_end;

    assign take      = cam_valid && read_en;
    assign last_take = take && byte_sel;
    assign rd_ready  = !word_valid || last_take;
    assign load      = rd_valid && rd_ready;

    assign cam_valid = word_valid;
    assign cam_data  = byte_sel ? word_q.bytes[0] : word_q.bytes[1];
    assign cam_row   = row;

    assign x_end   = (x == X_W'(H_ACT - 1));
    assign row_end = (row == ROW_W'(ROWS - 1));

    always_ff @(posedge rclk) begin
        if (load) begin
            word_q <= rd_data;
        end
    end

    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            word_valid <= 1'b0;
            byte_sel   <= 1'b0;
        end else if (load) begin
            word_valid <= 1'b1; // next word right behind the last byte.
            byte_sel   <= 1'b0;
        end else if (last_take) begin
            word_valid <= 1'b0;
            byte_sel   <= 1'b0;
        end else if (take) begin
            byte_sel <= 1'b1;
        end
    end

    // x and row advance on every byte handed over.
    always_ff @(posedge rclk or posedge cam_vsync) begin
        if (cam_vsync) begin
            x   <= '0;
            row <= '0;
        end else if (take) begin
            if (x_end) begin
                x   <= '0;
                row <= row_end ? '0 : row + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule : byte_reader

//--- logic/line_buffer.sv
module line_buffer #(
    parameter int H_ACT      = 1280,
    parameter int V_ACT      = 720,
    parameter int FIFO_DEPTH = 2560 // two lines.
) (
    input  logic                         rclk,
    input  logic                         cam_vsync,
    input  logic                         trig,
    input  logic [24:0]                  cam_pack,
    input  logic                         read_en,
    output logic                         cam_valid,
    output logic [7:0]                   cam_data,
    output logic [$clog2(2 * V_ACT)-1:0] cam_row,
    output logic                         aquire,
    output logic                         error
);

    logic                       wr_en;
    line_buffer_pkg::pixel565_t wr_data;
    line_buffer_pkg::pixel565_t rd_data;
    logic                       rd_valid;
    logic                       rd_ready;

    // camera side.
    pixel_capture #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) i_pixel_capture (
        .rclk     (rclk),
        .cam_vsync(cam_vsync),
        .trig     (trig),
        .cam_pack (cam_pack),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    line_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .H_ACT     (H_ACT)
    ) i_line_fifo (
        .rclk     (rclk),
        .cam_vsync(cam_vsync),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_ready (rd_ready),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .aquire   (aquire),
        .error    (error)
    );

    // consumer side.
    byte_reader #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) i_byte_reader (
        .rclk     (rclk),
        .cam_vsync(cam_vsync),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .read_en  (read_en),
        .rd_ready (rd_ready),
        .cam_valid(cam_valid),
        .cam_data (cam_data),
        .cam_row  (cam_row)
    );

endmodule : line_buffer

//--- testbench/tb_line_buffer.sv
module tb_line_buffer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACT        = 8;
    localparam int V_ACT        = 4;
    localparam int FIFO_DEPTH   = 16;
    localparam int ROWS         = 2 * V_ACT;
    localparam int ROW_W        = $clog2(ROWS);
    localparam int FRAME_PIX    = H_ACT * V_ACT;
    localparam int OVF_PIX      = FIFO_DEPTH + 8;
    localparam int MARGIN       = 16;
    localparam int CLK_PERIOD   = 40;
    localparam int BYTE_TIMEOUT = 200;
    localparam int TOTAL_PIX    = 5 * FRAME_PIX + OVF_PIX;
    localparam int TOTAL_BYTES  = 2 * (3 * FRAME_PIX + FIFO_DEPTH + 1);
    localparam int WATCHDOG_NS  = (TOTAL_PIX + TOTAL_BYTES) * 4 * CLK_PERIOD;

    logic             rclk;
    logic             cam_vsync;
    logic             trig;
    logic [24:0]      cam_pack;
    logic             read_en;
    logic             cam_valid;
    logic [7:0]       cam_data;
    logic [ROW_W-1:0] cam_row;
    logic             aquire;
    logic             error;

    line_buffer_pkg::pixel565_t exp_q[$]; // expected words in send order.
    int errors;
    int pass_count;
    int fail_count;

    line_buffer #(
        .H_ACT     (H_ACT),
        .V_ACT     (V_ACT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_line_buffer (
        .rclk     (rclk),
        .cam_vsync(cam_vsync),
        .trig     (trig),
        .cam_pack (cam_pack),
        .read_en  (read_en),
        .cam_valid(cam_valid),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .aquire   (aquire),
        .error    (error)
    );

    initial begin
        rclk = 1'b0;
        forever #(CLK_PERIOD / 2) rclk = ~rclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic compare_pixel(input logic [7:0] hi, input logic [7:0] lo,
                                 input line_buffer_pkg::pixel565_t exp, input int idx);
        line_buffer_pkg::pixel565_t got;
        got.bytes[1] = hi;
        got.bytes[0] = lo;
        if (got !== exp) begin
            $display("** Error at %0t: pixel %0d got %h, expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic compare_row(input logic [ROW_W-1:0] got, input logic [ROW_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic apply_reset();
        @(posedge rclk);
        cam_vsync <= 1'b1;
        trig      <= 1'b0;
        cam_pack  <= '0;
        read_en   <= 1'b0;
        repeat (2) @(posedge rclk);
        cam_vsync <= 1'b0;
        exp_q.delete();
    endtask

    task automatic pulse_trig();
        @(posedge rclk);
        trig <= 1'b1;
        @(posedge rclk);
        trig <= 1'b0;
    endtask

    // late_trig indexes the pixel that carries a trigger. -1 sends none.
    task automatic send_frame(input int n_pix, input int idle, input int late_trig,
                              input int keep);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        line_buffer_pkg::pixel565_t exp;
        for (int i = 0; i < n_pix; i++) begin
            r = 8'($urandom);
            g = 8'($urandom);
            b = 8'($urandom);
            @(posedge rclk);
            cam_pack <= {1'b1, r, g, b};
            trig     <= (i == late_trig);
            if (i < keep) begin
                exp.rgb.r = r[7:3]; // plain truncation to 5/6/5.
                exp.rgb.g = g[7:2];
                exp.rgb.b = b[7:3];
                exp_q.push_back(exp);
            end
            repeat (idle) begin
                @(posedge rclk);
                cam_pack <= '0;
                trig     <= 1'b0;
            end
        end
        @(posedge rclk);
        cam_pack <= '0;
        trig     <= 1'b0;
    endtask

    // byte is taken at the posedge after the sampling negedge.
    task automatic collect_byte(input bit random_ready, output logic [7:0] data,
                                output logic [ROW_W-1:0] row, output bit ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        while (!ok && waited < BYTE_TIMEOUT) begin
            @(posedge rclk);
            read_en <= random_ready ? 1'($urandom) : 1'b1;
            @(negedge rclk);
            if (cam_valid && read_en) begin
                data = cam_data;
                row  = cam_row;
                ok   = 1'b1;
            end
            waited++;
        end
        if (!ok) begin
            $display("missing output: no byte from the DUT within %0d cycles at %0t",
                     BYTE_TIMEOUT, $time);
            errors++;
        end
    endtask

    task automatic read_frame(input int n_pix, input bit random_ready);
        logic [7:0]       hi;
        logic [7:0]       lo;
        logic [ROW_W-1:0] row;
        bit               ok;
        for (int i = 0; i < n_pix; i++) begin
            collect_byte(random_ready, hi, row, ok);
            if (!ok) return;
            compare_row(row, ROW_W'(((2 * i) / H_ACT) % ROWS), "row of high byte");
            collect_byte(random_ready, lo, row, ok);
            if (!ok) return;
            compare_row(row, ROW_W'(((2 * i + 1) / H_ACT) % ROWS), "row of low byte");
            if (exp_q.size() == 0) begin
                $display("unexpected extra pixel %0d from the DUT at %0t", i, $time);
                errors++;
            end else begin
                compare_pixel(hi, lo, exp_q.pop_front(), i);
            end
        end
        @(posedge rclk);
        read_en <= 1'b0;
    endtask

    task automatic watch_idle(input int cycles, output bit seen);
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge rclk);
            if (cam_valid) seen = 1'b1;
        end
    endtask

    task automatic wait_for_aquire(input int cycles, output bit seen);
        int waited;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < cycles) begin
            @(negedge rclk);
            seen = aquire;
            waited++;
        end
    endtask

    task automatic run_capture(input int idle, input bit random_ready);
        pulse_trig();
        fork
            send_frame(FRAME_PIX, idle, -1, FRAME_PIX);
            read_frame(FRAME_PIX, random_ready);
        join
    endtask

    task automatic check_outputs_idle(input string when);
        compare_flag(cam_valid, 1'b0, {when, " cam_valid"});
        compare_flag(aquire, 1'b0, {when, " aquire"});
        compare_flag(error, 1'b0, {when, " error"});
        compare_row(cam_row, '0, {when, " cam_row"});
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = errors;
        @(posedge rclk);
        cam_vsync <= 1'b1;
        @(negedge rclk);
        check_outputs_idle("during reset");
        repeat (2) @(posedge rclk);
        cam_vsync <= 1'b0;
        @(negedge rclk);
        check_outputs_idle("after reset");
        report_test("reset", errs_before);
    endtask

    task automatic test_triggered_frame();
        int errs_before;
        bit seen;
        errs_before = errors;
        apply_reset();
        pulse_trig();
        fork
            send_frame(FRAME_PIX, 1, -1, FRAME_PIX);
            begin
                // reading held off until a whole line sits in the FIFO.
                wait_for_aquire(4 * FRAME_PIX, seen);
                compare_flag(seen, 1'b1, "aquire before reading");
                // one word waits in the reader, the line behind it in the FIFO.
                compare_flag(exp_q.size() > H_ACT, 1'b1, "whole line sent before aquire");
                read_frame(FRAME_PIX, 1'b0);
            end
        join
        @(negedge rclk);
        compare_row(cam_row, '0, "row after full frame");
        report_test("triggered frame", errs_before);
    endtask

    task automatic test_no_trigger();
        int errs_before;
        bit seen;
        errs_before = errors;
        apply_reset();
        fork
            send_frame(FRAME_PIX, 0, -1, 0);
            watch_idle(FRAME_PIX + MARGIN, seen);
        join
        compare_flag(seen, 1'b0, "cam_valid without trigger");
        report_test("no trigger", errs_before);
    endtask

    task automatic test_late_trigger();
        int errs_before;
        bit seen;
        errs_before = errors;
        apply_reset();
        fork
            send_frame(FRAME_PIX, 0, 1, 0); // trigger rides on the second pixel.
            watch_idle(FRAME_PIX + MARGIN, seen);
        join
        compare_flag(seen, 1'b0, "cam_valid after late trigger");
        apply_reset();
        run_capture(1, 1'b0);
        report_test("late trigger", errs_before);
    endtask

    task automatic test_overflow();
        int errs_before;
        bit seen;
        errs_before = errors;
        apply_reset();
        pulse_trig();
        // the reader keeps one word and the FIFO the next FIFO_DEPTH.
        send_frame(OVF_PIX, 0, -1, FIFO_DEPTH + 1);
        @(negedge rclk);
        compare_flag(error, 1'b1, "error after overflow");
        read_frame(FIFO_DEPTH + 1, 1'b0);
        watch_idle(MARGIN, seen);
        compare_flag(seen, 1'b0, "cam_valid after stored words");
        apply_reset();
        @(negedge rclk);
        compare_flag(error, 1'b0, "error after cam_vsync");
        report_test("overflow", errs_before);
    endtask

    task automatic test_read_backpressure();
        int errs_before;
        errs_before = errors;
        apply_reset();
        run_capture(4, 1'b1); // pixel spacing keeps the FIFO from filling.
        @(negedge rclk);
        compare_flag(error, 1'b0, "error under back-pressure");
        report_test("read back-pressure", errs_before);
    endtask

    initial begin
        cam_vsync  = 1'b1;
        trig       = 1'b0;
        cam_pack   = '0;
        read_en    = 1'b0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'he0c9_23f3));
        test_reset();
        test_triggered_frame();
        test_no_trigger();
        test_late_trigger();
        test_overflow();
        test_read_backpressure();
        $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_line_buffer

//--- line_buffer.f
logic/line_buffer_pkg.sv
logic/pixel_capture.sv
logic/line_fifo.sv
logic/byte_reader.sv
logic/line_buffer.sv
testbench/tb_line_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the line buffer testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary \
    -f line_buffer.f \
    --top-module tb_line_buffer \
    --Mdir obj_dir

./obj_dir/Vtb_line_buffer > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi
